// File: include/csr_params.svh
`ifndef CSR_PARAMS_SVH
`define CSR_PARAMS_SVH

// data width
`define XLEN            64

// machine CSR addresses
`define CSR_MSTATUS     12'h300
`define CSR_MIE         12'h304
`define CSR_MTVEC       12'h305
`define CSR_MEPC        12'h341
`define CSR_MCAUSE      12'h342
`define CSR_MIP         12'h344

// funct3 of the zicsr instructions
`define F3_CSRRW        3'b001
`define F3_CSRRS        3'b010
`define F3_CSRRC        3'b011
`define F3_CSRRWI       3'b101
`define F3_CSRRSI       3'b110
`define F3_CSRRCI       3'b111

// opcode[6:2] of ecall, mret and csr*
`define OPC_SYSTEM      5'b11100

// internal CSR operation codes
`define CSR_OP_NONE     2'b00
`define CSR_OP_RW       2'b01
`define CSR_OP_RS       2'b10
`define CSR_OP_RC       2'b11

// reset value and trap causes
`define MSTATUS_RESET   64'h0000_000a_0000_1800
`define CAUSE_ECALL_M   64'd11
`define CAUSE_MTIMER    64'h8000_0000_0000_0007

`endif

// File: run_sim.sh
#!/bin/sh
# build the CSR unit testbench with Verilator, run it and look for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/100ps \
    -f src.f --top-module tb_csr_unit -o sim_csr_unit &&
./obj_dir/sim_csr_unit | tee /dev/stderr | grep -x -F "Finished with no errors" > /dev/null &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }

// File: src.f
+incdir+include
src/csr_pkg.sv
src/csr_instr_decode.sv
src/csr_regfile.sv
src/csr_output_stage.sv
src/csr_unit_top.sv
verification/tb_csr_unit.sv

// File: src/csr_instr_decode.sv
`include "csr_params.svh"

module csr_instr_decode (
    input  logic              instr_valid_i,
    input  logic [31:0]       instr_i,
    input  csr_pkg::xlen_t    csr_wr_data_i,
    input  csr_pkg::xlen_t    pc_i,
    output csr_pkg::csr_req_t req_o
);
    import csr_pkg::*;

    // funct3 of the privileged group and its immediates
    localparam logic [2:0]  F3_PRIV   = 3'b000;
    localparam logic [11:0] IMM_ECALL = 12'h000;
    localparam logic [11:0] IMM_MRET  = 12'h302;

    logic [4:0] opcode;
    logic [2:0] funct3;
    csr_addr_t  imm12;
    logic       is_system;
    logic       is_priv;
    csr_op_t    op;

    assign opcode = instr_i[6:2];
    assign funct3 = instr_i[14:12];
    assign imm12  = instr_i[31:20];

    // 32-bit encodings only
    assign is_system = instr_valid_i && (instr_i[1:0] == 2'b11) && (opcode == `OPC_SYSTEM);
    assign is_priv   = is_system && (funct3 == F3_PRIV);

    // register and immediate forms share an op, the pipeline supplies the operand
    always_comb begin
        op = `CSR_OP_NONE;
        if (is_system) begin
            case (funct3)
                `F3_CSRRW,
                `F3_CSRRWI: op = `CSR_OP_RW;
                `F3_CSRRS,
                `F3_CSRRSI: op = `CSR_OP_RS;
                `F3_CSRRC,
                `F3_CSRRCI: op = `CSR_OP_RC;
                default:    op = `CSR_OP_NONE;
            endcase
        end
    end

    always_comb begin
        req_o.valid    = (op != `CSR_OP_NONE);
        req_o.op       = op;
        req_o.addr     = imm12;
        req_o.wdata    = csr_wr_data_i;
        req_o.is_ecall = is_priv && (imm12 == IMM_ECALL);
        req_o.is_mret  = is_priv && (imm12 == IMM_MRET);
        req_o.epc      = pc_i;
    end

    // ecall and mret share funct3 and differ only in the immediate
    always_comb begin
        if (instr_valid_i) begin
            assert (!(req_o.is_ecall && req_o.is_mret))
                else $error("decode flags ecall and mret together");
        end
    end

endmodule

// File: src/csr_output_stage.sv
`include "csr_params.svh"

module csr_output_stage (
    input  csr_pkg::csr_req_t   req_i,
    input  csr_pkg::csr_state_t state_i,
    input  logic                stall_n_i,
    output csr_pkg::xlen_t      rd_data_o,
    output csr_pkg::redirect_t  redirect_o,
    output logic                intr_pending_o
);

    logic sel_mstatus;
    logic sel_mie;
    logic sel_mtvec;
    logic sel_mepc;
    logic sel_mcause;
    logic sel_mip;
    logic trap_entry;

    assign sel_mstatus = req_i.valid && (req_i.addr == `CSR_MSTATUS);
    assign sel_mie     = req_i.valid && (req_i.addr == `CSR_MIE);
    assign sel_mtvec   = req_i.valid && (req_i.addr == `CSR_MTVEC);
    assign sel_mepc    = req_i.valid && (req_i.addr == `CSR_MEPC);
    assign sel_mcause  = req_i.valid && (req_i.addr == `CSR_MCAUSE);
    assign sel_mip     = req_i.valid && (req_i.addr == `CSR_MIP);

    // and-or mux, an unselected CSR keeps the read bus quiet
    assign rd_data_o = ({`XLEN{sel_mstatus}} & state_i.mstatus)
                     | ({`XLEN{sel_mie}}     & state_i.mie)
                     | ({`XLEN{sel_mtvec}}   & state_i.mtvec)
                     | ({`XLEN{sel_mepc}}    & state_i.mepc)
                     | ({`XLEN{sel_mcause}}  & state_i.mcause)
                     | ({`XLEN{sel_mip}}     & state_i.mip);

    // interrupt and ecall enter the trap vector, mret returns
    assign trap_entry = state_i.intr_take || req_i.is_ecall;

    always_comb begin
        redirect_o.valid = stall_n_i && (trap_entry || req_i.is_mret);
        redirect_o.pc    = trap_entry ? state_i.mtvec : state_i.mepc;
    end

    assign intr_pending_o = state_i.intr_take;

    // fetch cannot take a misaligned target
    always_comb begin
        if (redirect_o.valid) begin
            assert (redirect_o.pc[1:0] == 2'b00)
                else $error("redirect target is not word aligned");
        end
    end

endmodule

// File: src/csr_pkg.sv
`include "csr_params.svh"

package csr_pkg;

    // machine word
    typedef logic [`XLEN-1:0] xlen_t;

    // 12-bit CSR index from instr[31:20]
    typedef logic [11:0] csr_addr_t;

    // none, rw, rs, rc
    typedef logic [1:0] csr_op_t;

    // decoded request from the execute stage instruction
    typedef struct packed {
        logic      valid;
        csr_op_t   op;
        csr_addr_t addr;
        xlen_t     wdata;
        logic      is_ecall;
        logic      is_mret;
        xlen_t     epc;
    } csr_req_t;

    // PCs of the three front stages, used to pick the interrupt return address
    typedef struct packed {
        xlen_t ex_pc;
        xlen_t id_pc;
        xlen_t if_pc;
    } pipe_pc_t;

    // current CSR contents plus the interrupt-take flag
    typedef struct packed {
        xlen_t mstatus;
        xlen_t mie;
        xlen_t mtvec;
        xlen_t mepc;
        xlen_t mcause;
        xlen_t mip;
        logic  intr_take;
    } csr_state_t;

    // PC redirect towards fetch
    typedef struct packed {
        logic  valid;
        xlen_t pc;
    } redirect_t;

endpackage

// File: src/csr_regfile.sv
`include "csr_params.svh"

module csr_regfile (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                stall_n_i,
    input  logic                timer_int_i,
    input  csr_pkg::csr_req_t   req_i,
    input  csr_pkg::pipe_pc_t   pipe_pc_i,
    input  csr_pkg::xlen_t      rd_data_i,
    output csr_pkg::csr_state_t state_o
);
    import csr_pkg::*;

    // mstatus fields
    localparam int MIE_BIT  = 3;
    localparam int MPIE_BIT = 7;
    localparam int MPP_LO   = 11;
    localparam int MPP_HI   = 12;
    // machine timer bit in mie and mip
    localparam int MTI_BIT  = 7;

    xlen_t mstatus_q;
    xlen_t mie_q;
    xlen_t mtvec_q;
    xlen_t mepc_q;
    xlen_t mcause_q;
    xlen_t mip_q;

    xlen_t mstatus_d;
    xlen_t mie_d;
    xlen_t mtvec_d;
    xlen_t mepc_d;
    xlen_t mcause_d;
    xlen_t mip_d;

    xlen_t wr_val;
    xlen_t intr_epc;
    logic  intr_take;
    logic  take_intr;
    logic  take_ecall;
    logic  take_mret;
    logic  sw_wr;
    logic  timer_set;

    assign intr_take = mip_q[MTI_BIT] && mstatus_q[MIE_BIT];

    // one event per edge, interrupt first
    assign take_intr  = stall_n_i && intr_take;
    assign take_ecall = stall_n_i && !intr_take && req_i.is_ecall;
    assign take_mret  = stall_n_i && !intr_take && !req_i.is_ecall && req_i.is_mret;
    assign sw_wr      = stall_n_i && !intr_take && !req_i.is_ecall && !req_i.is_mret
                        && req_i.valid;

    // timer pulse is latched even while stalled
    assign timer_set = timer_int_i && mie_q[MTI_BIT] && mstatus_q[MIE_BIT];

    // rd_data_i is the old value of the addressed CSR
    always_comb begin
        case (req_i.op)
            `CSR_OP_RW: wr_val = req_i.wdata;
            `CSR_OP_RS: wr_val = rd_data_i | req_i.wdata;
            `CSR_OP_RC: wr_val = rd_data_i & ~req_i.wdata;
            default:    wr_val = rd_data_i;
        endcase
    end

    // oldest instruction still in flight becomes the return address
    always_comb begin
        if (pipe_pc_i.ex_pc != '0) begin
            intr_epc = pipe_pc_i.ex_pc;
        end else if (pipe_pc_i.id_pc != '0) begin
            intr_epc = pipe_pc_i.id_pc;
        end else begin
            intr_epc = pipe_pc_i.if_pc;
        end
    end

    always_comb begin
        mstatus_d = mstatus_q;
        mie_d     = mie_q;
        mtvec_d   = mtvec_q;
        mepc_d    = mepc_q;
        mcause_d  = mcause_q;
        mip_d     = mip_q;

        if (take_intr || take_ecall) begin
            mstatus_d[MPIE_BIT]      = mstatus_q[MIE_BIT];
            mstatus_d[MIE_BIT]       = 1'b0;
            mstatus_d[MPP_HI:MPP_LO] = 2'b11;
            if (take_intr) begin
                mepc_d          = intr_epc;
                mcause_d        = `CAUSE_MTIMER;
                mip_d[MTI_BIT]  = 1'b0;
            end else begin
                mepc_d   = req_i.epc;
                mcause_d = `CAUSE_ECALL_M;
            end
        end else if (take_mret) begin
            mstatus_d[MIE_BIT]  = mstatus_q[MPIE_BIT];
            mstatus_d[MPIE_BIT] = 1'b1;
        end else if (sw_wr) begin
            case (req_i.addr)
                `CSR_MSTATUS: mstatus_d = wr_val;
                `CSR_MIE:     mie_d     = wr_val;
                `CSR_MTVEC:   mtvec_d   = wr_val;
                `CSR_MEPC:    mepc_d    = wr_val;
                `CSR_MCAUSE:  mcause_d  = wr_val;
                `CSR_MIP:     mip_d     = wr_val;
                default:      ;
            endcase
        end

        // direct mode only, word aligned targets
        mtvec_d[1:0] = 2'b00;
        mepc_d[1:0]  = 2'b00;

        if (timer_set) begin
            mip_d[MTI_BIT] = 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mstatus_q <= `MSTATUS_RESET;
            mie_q     <= '0;
            mtvec_q   <= '0;
            mepc_q    <= '0;
            mcause_q  <= '0;
            mip_q     <= '0;
        end else begin
            mstatus_q <= mstatus_d;
            mie_q     <= mie_d;
            mtvec_q   <= mtvec_d;
            mepc_q    <= mepc_d;
            mcause_q  <= mcause_d;
            mip_q     <= mip_d;
        end
    end

    always_comb begin
        state_o.mstatus   = mstatus_q;
        state_o.mie       = mie_q;
        state_o.mtvec     = mtvec_q;
        state_o.mepc      = mepc_q;
        state_o.mcause    = mcause_q;
        state_o.mip       = mip_q;
        state_o.intr_take = intr_take;
    end

    // redirect targets must stay fetchable across every update path
    assert property (@(posedge clk) disable iff (!rst_n)
        (mtvec_q[1:0] == 2'b00) && (mepc_q[1:0] == 2'b00))
        else $error("mtvec or mepc lost word alignment");

    // interrupt entry masks further interrupts
    assert property (@(posedge clk) disable iff (!rst_n)
        (intr_take && stall_n_i) |=> !mstatus_q[MIE_BIT])
        else $error("MIE not cleared on interrupt entry");

    // stalled pipeline must not move the return address
    assert property (@(posedge clk) disable iff (!rst_n)
        !stall_n_i |=> $stable(mepc_q))
        else $error("mepc changed during a stall");

endmodule

// File: src/csr_unit_top.sv
module csr_unit_top (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               instr_valid_i,
    input  logic [31:0]        instr_i,
    input  csr_pkg::xlen_t     csr_wr_data_i,
    input  csr_pkg::xlen_t     pc_i,
    input  csr_pkg::xlen_t     ex_pc_i,
    input  csr_pkg::xlen_t     id_pc_i,
    input  csr_pkg::xlen_t     if_pc_i,
    input  logic               stall_n_i,
    input  logic               timer_int_i,
    output csr_pkg::xlen_t     csr_data_o,
    output logic               intr_pending_o,
    output csr_pkg::redirect_t redirect_o
);
    import csr_pkg::*;

    csr_req_t   req;
    csr_state_t state;
    pipe_pc_t   pipe_pc;
    xlen_t      rd_data;

    assign pipe_pc = '{ex_pc: ex_pc_i, id_pc: id_pc_i, if_pc: if_pc_i};

    // read value also feeds back for set and clear
    assign csr_data_o = rd_data;

    csr_instr_decode u_decode (
        .instr_valid_i (instr_valid_i),
        .instr_i       (instr_i),
        .csr_wr_data_i (csr_wr_data_i),
        .pc_i          (pc_i),
        .req_o         (req)
    );

    csr_regfile u_regfile (
        .clk         (clk),
        .rst_n       (rst_n),
        .stall_n_i   (stall_n_i),
        .timer_int_i (timer_int_i),
        .req_i       (req),
        .pipe_pc_i   (pipe_pc),
        .rd_data_i   (rd_data),
        .state_o     (state)
    );

    csr_output_stage u_output (
        .req_i          (req),
        .state_i        (state),
        .stall_n_i      (stall_n_i),
        .rd_data_o      (rd_data),
        .redirect_o     (redirect_o),
        .intr_pending_o (intr_pending_o)
    );

endmodule

// File: verification/tb_csr_unit.sv
`include "csr_params.svh"

module tb_csr_unit;
    timeunit 1ns;
    timeprecision 100ps;
    import csr_pkg::*;

    localparam int NUM_TESTS       = 5;
    localparam int CLK_PERIOD      = 8;
    localparam int CYCLES_PER_TEST = 200;
    localparam logic [11:0] CSR_UNKNOWN = 12'h7c0;
    localparam logic [31:0] INSTR_ECALL = 32'h0000_0073;
    localparam logic [31:0] INSTR_MRET  = 32'h3020_0073;
    localparam logic [31:0] INSTR_NOP   = 32'h0000_0013;

    logic        clk;
    logic        rst_n;
    logic        instr_valid_i;
    logic [31:0] instr_i;
    xlen_t       csr_wr_data_i;
    xlen_t       pc_i;
    xlen_t       ex_pc_i;
    xlen_t       id_pc_i;
    xlen_t       if_pc_i;
    logic        stall_n_i;
    logic        timer_int_i;
    xlen_t       csr_data_o;
    logic        intr_pending_o;
    redirect_t   redirect_o;

    // reference copy of the six CSRs
    xlen_t m_mstatus;
    xlen_t m_mie;
    xlen_t m_mtvec;
    xlen_t m_mepc;
    xlen_t m_mcause;
    xlen_t m_mip;

    int          error_count;
    int          test_errors;
    int          tests_done;
    xlen_t       last_rd;
    xlen_t       last_redir;
    logic        last_pending;

    csr_addr_t  csr_list [6] = '{`CSR_MSTATUS, `CSR_MIE, `CSR_MTVEC,
                                 `CSR_MEPC, `CSR_MCAUSE, `CSR_MIP};
    logic [2:0] f3_list [6]  = '{`F3_CSRRW, `F3_CSRRS, `F3_CSRRC,
                                 `F3_CSRRWI, `F3_CSRRSI, `F3_CSRRCI};

    csr_unit_top DUT (
        .clk            (clk),
        .rst_n          (rst_n),
        .instr_valid_i  (instr_valid_i),
        .instr_i        (instr_i),
        .csr_wr_data_i  (csr_wr_data_i),
        .pc_i           (pc_i),
        .ex_pc_i        (ex_pc_i),
        .id_pc_i        (id_pc_i),
        .if_pc_i        (if_pc_i),
        .stall_n_i      (stall_n_i),
        .timer_int_i    (timer_int_i),
        .csr_data_o     (csr_data_o),
        .intr_pending_o (intr_pending_o),
        .redirect_o     (redirect_o)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // run limit scales with the number of tests
    initial begin
        #(NUM_TESTS * CYCLES_PER_TEST * CLK_PERIOD);
        $display("timeout: the tests did not finish within %0d cycles",
                 NUM_TESTS * CYCLES_PER_TEST);
        $display("Finished with errors");
        $finish;
    end

    task automatic check(input string name, input xlen_t expected, input xlen_t actual);
        if (expected !== actual) begin
            $display("error: %s expected %h actual %h", name, expected, actual);
            error_count++;
            test_errors++;
        end
    endtask

    task automatic finish_test(input string name);
        $display("test %s done, %0d errors", name, test_errors);
        tests_done++;
        test_errors = 0;
    endtask

    task automatic model_reset();
        m_mstatus = `MSTATUS_RESET;
        m_mie     = '0;
        m_mtvec   = '0;
        m_mepc    = '0;
        m_mcause  = '0;
        m_mip     = '0;
    endtask

    function automatic xlen_t model_read(input csr_addr_t addr);
        case (addr)
            `CSR_MSTATUS: return m_mstatus;
            `CSR_MIE:     return m_mie;
            `CSR_MTVEC:   return m_mtvec;
            `CSR_MEPC:    return m_mepc;
            `CSR_MCAUSE:  return m_mcause;
            `CSR_MIP:     return m_mip;
            default:      return '0;
        endcase
    endfunction

    function automatic csr_op_t op_of(input logic [2:0] f3);
        case (f3)
            `F3_CSRRW, `F3_CSRRWI: return `CSR_OP_RW;
            `F3_CSRRS, `F3_CSRRSI: return `CSR_OP_RS;
            `F3_CSRRC, `F3_CSRRCI: return `CSR_OP_RC;
            default:               return `CSR_OP_NONE;
        endcase
    endfunction

    // oldest nonzero PC of ex, id, if
    function automatic xlen_t intr_return_pc();
        if (ex_pc_i != '0) return ex_pc_i;
        if (id_pc_i != '0) return id_pc_i;
        return if_pc_i;
    endfunction

    // model update at one rising edge
    task automatic model_edge(input csr_op_t op, input csr_addr_t addr, input xlen_t opnd,
                              input logic ecall, input logic mret, input xlen_t epc,
                              input logic stall_n, input logic timer);
        xlen_t old_val;
        xlen_t wv;
        logic  take;
        logic  tset;
        old_val = (op != `CSR_OP_NONE) ? model_read(addr) : '0;
        take    = m_mip[7] && m_mstatus[3];
        tset    = timer && m_mie[7] && m_mstatus[3];
        if (stall_n) begin
            if (take || ecall) begin
                m_mstatus[7]     = m_mstatus[3];
                m_mstatus[3]     = 1'b0;
                m_mstatus[12:11] = 2'b11;
                m_mepc           = take ? intr_return_pc() : epc;
                m_mcause         = take ? `CAUSE_MTIMER : `CAUSE_ECALL_M;
                if (take) begin
                    m_mip[7] = 1'b0;
                end
            end else if (mret) begin
                m_mstatus[3] = m_mstatus[7];
                m_mstatus[7] = 1'b1;
            end else if (op != `CSR_OP_NONE) begin
                case (op)
                    `CSR_OP_RW: wv = opnd;
                    `CSR_OP_RS: wv = old_val | opnd;
                    default:    wv = old_val & ~opnd;
                endcase
                case (addr)
                    `CSR_MSTATUS: m_mstatus = wv;
                    `CSR_MIE:     m_mie     = wv;
                    `CSR_MTVEC:   m_mtvec   = wv;
                    `CSR_MEPC:    m_mepc    = wv;
                    `CSR_MCAUSE:  m_mcause  = wv;
                    `CSR_MIP:     m_mip     = wv;
                    default:      ;
                endcase
            end
        end
        m_mtvec[1:0] = 2'b00;
        m_mepc[1:0]  = 2'b00;
        if (tset) begin
            m_mip[7] = 1'b1;
        end
    endtask

    // one cycle: drive, check the combinational outputs, step the model at the edge
    task automatic apply(input string name, input logic [31:0] instr, input csr_op_t op,
                         input csr_addr_t addr, input logic ecall, input logic mret,
                         input xlen_t opnd, input xlen_t pc, input logic stall_n,
                         input logic timer);
        xlen_t exp_rd;
        logic  take;
        logic  exp_valid;
        xlen_t exp_pc;
        instr_valid_i = 1'b1;
        instr_i       = instr;
        csr_wr_data_i = opnd;
        pc_i          = pc;
        stall_n_i     = stall_n;
        timer_int_i   = timer;
        #2;
        exp_rd    = (op != `CSR_OP_NONE) ? model_read(addr) : '0;
        take      = m_mip[7] && m_mstatus[3];
        exp_valid = stall_n && (take || ecall || mret);
        exp_pc    = (take || ecall) ? m_mtvec : m_mepc;
        check({name, " read"}, exp_rd, csr_data_o);
        check({name, " pending"}, xlen_t'(take), xlen_t'(intr_pending_o));
        check({name, " redirect valid"}, xlen_t'(exp_valid), xlen_t'(redirect_o.valid));
        if (exp_valid) begin
            check({name, " redirect pc"}, exp_pc, redirect_o.pc);
        end
        last_rd      = csr_data_o;
        last_redir   = redirect_o.pc;
        last_pending = intr_pending_o;
        @(posedge clk);
        model_edge(op, addr, opnd, ecall, mret, pc, stall_n, timer);
        #1;
    endtask

    task automatic csr_access(input string name, input logic [2:0] f3, input csr_addr_t addr,
                              input xlen_t opnd, input logic stall_n);
        logic [4:0] rs1;
        xlen_t      value;
        // immediate forms carry the operand in the rs1 field
        rs1   = f3[2] ? opnd[4:0] : 5'd1;
        value = f3[2] ? {59'd0, opnd[4:0]} : opnd;
        apply(name, {addr, rs1, f3, 5'd2, 7'b1110011}, op_of(f3), addr, 1'b0, 1'b0,
              value, 64'd0, stall_n, 1'b0);
    endtask

    task automatic read_csr(input string name, input csr_addr_t addr);
        csr_access(name, `F3_CSRRS, addr, 64'd0, 1'b1);
    endtask

    task automatic idle(input string name, input logic timer);
        apply(name, INSTR_NOP, `CSR_OP_NONE, '0, 1'b0, 1'b0, 64'd0, 64'd0, 1'b1, timer);
    endtask

    task automatic test_reset_values();
        foreach (csr_list[i]) begin
            read_csr("reset_values", csr_list[i]);
        end
        read_csr("reset_values", `CSR_MSTATUS);
        check("reset_values mstatus", 64'h0000_000a_0000_1800, last_rd);
        finish_test("reset_values");
    endtask

    task automatic test_csr_ops();
        xlen_t opnd;
        foreach (csr_list[i]) begin
            foreach (f3_list[j]) begin
                opnd = {$urandom, $urandom};
                // no timer interrupt from software writes here
                if (csr_list[i] == `CSR_MIP) begin
                    opnd[7] = 1'b0;
                end
                csr_access("csr_ops", f3_list[j], csr_list[i], opnd, 1'b1);
                read_csr("csr_ops", csr_list[i]);
                if (csr_list[i] == `CSR_MTVEC || csr_list[i] == `CSR_MEPC) begin
                    check("csr_ops alignment", 64'd0, xlen_t'(last_rd[1:0]));
                end
            end
        end
        csr_access("csr_ops unknown", `F3_CSRRW, CSR_UNKNOWN, {$urandom, $urandom}, 1'b1);
        foreach (csr_list[i]) begin
            read_csr("csr_ops unknown", csr_list[i]);
        end
        finish_test("csr_ops");
    endtask

    task automatic test_stall();
        csr_access("stall write", `F3_CSRRW, `CSR_MTVEC, {$urandom, $urandom}, 1'b0);
        csr_access("stall set", `F3_CSRRS, `CSR_MSTATUS, {$urandom, $urandom}, 1'b0);
        apply("stall ecall", INSTR_ECALL, `CSR_OP_NONE, '0, 1'b1, 1'b0, 64'd0,
              {$urandom, $urandom}, 1'b0, 1'b0);
        apply("stall mret", INSTR_MRET, `CSR_OP_NONE, '0, 1'b0, 1'b1, 64'd0, 64'd0,
              1'b0, 1'b0);
        foreach (csr_list[i]) begin
            read_csr("stall", csr_list[i]);
        end
        finish_test("stall");
    endtask

    task automatic test_ecall_mret();
        xlen_t vec;
        xlen_t epc;
        logic  old_mie;
        vec = {$urandom, $urandom};
        epc = {$urandom, $urandom};
        csr_access("ecall_mret", `F3_CSRRW, `CSR_MTVEC, vec, 1'b1);
        csr_access("ecall_mret", `F3_CSRRSI, `CSR_MSTATUS, 64'd8, 1'b1);
        old_mie = m_mstatus[3];
        apply("ecall_mret ecall", INSTR_ECALL, `CSR_OP_NONE, '0, 1'b1, 1'b0, 64'd0, epc,
              1'b1, 1'b0);
        check("ecall_mret ecall target", vec & ~64'd3, last_redir);
        read_csr("ecall_mret", `CSR_MEPC);
        check("ecall_mret mepc", epc & ~64'd3, last_rd);
        read_csr("ecall_mret", `CSR_MCAUSE);
        check("ecall_mret mcause", 64'd11, last_rd);
        read_csr("ecall_mret", `CSR_MSTATUS);
        check("ecall_mret mie", 64'd0, xlen_t'(last_rd[3]));
        check("ecall_mret mpie", xlen_t'(old_mie), xlen_t'(last_rd[7]));
        check("ecall_mret mpp", 64'd3, xlen_t'(last_rd[12:11]));
        apply("ecall_mret mret", INSTR_MRET, `CSR_OP_NONE, '0, 1'b0, 1'b1, 64'd0, 64'd0,
              1'b1, 1'b0);
        check("ecall_mret mret target", epc & ~64'd3, last_redir);
        read_csr("ecall_mret", `CSR_MSTATUS);
        check("ecall_mret mie restored", xlen_t'(old_mie), xlen_t'(last_rd[3]));
        finish_test("ecall_mret");
    endtask

    task automatic test_timer();
        csr_access("timer", `F3_CSRRW, `CSR_MIP, 64'd0, 1'b1);
        csr_access("timer", `F3_CSRRW, `CSR_MIE, 64'h80, 1'b1);
        csr_access("timer", `F3_CSRRSI, `CSR_MSTATUS, 64'd8, 1'b1);
        // execute stage empty, decode stage holds the return address
        ex_pc_i = '0;
        id_pc_i = ({$urandom, $urandom} & ~64'd3) | 64'h100;
        if_pc_i = {$urandom, $urandom} | 64'h100;
        idle("timer pulse", 1'b1);
        idle("timer taken", 1'b0);
        check("timer pending", 64'd1, xlen_t'(last_pending));
        idle("timer after", 1'b0);
        check("timer pending cleared", 64'd0, xlen_t'(last_pending));
        read_csr("timer", `CSR_MEPC);
        check("timer mepc", id_pc_i, last_rd);
        read_csr("timer", `CSR_MCAUSE);
        check("timer mcause", 64'h8000_0000_0000_0007, last_rd);
        read_csr("timer", `CSR_MSTATUS);
        check("timer mie", 64'd0, xlen_t'(last_rd[3]));

        // MIE is clear now, pulse is ignored
        idle("timer masked pulse", 1'b1);
        idle("timer masked", 1'b0);
        check("timer masked pending", 64'd0, xlen_t'(last_pending));
        read_csr("timer", `CSR_MIP);
        check("timer masked mtip", 64'd0, xlen_t'(last_rd[7]));

        // ex stage occupied this time
        csr_access("timer", `F3_CSRRSI, `CSR_MSTATUS, 64'd8, 1'b1);
        ex_pc_i = ({$urandom, $urandom} & ~64'd3) | 64'h200;
        idle("timer pulse ex", 1'b1);
        idle("timer taken ex", 1'b0);
        check("timer pending ex", 64'd1, xlen_t'(last_pending));
        read_csr("timer", `CSR_MEPC);
        check("timer mepc ex", ex_pc_i, last_rd);
        ex_pc_i = '0;
        id_pc_i = '0;
        if_pc_i = '0;
        finish_test("timer");
    endtask

    initial begin
        void'($urandom(55747));
        rst_n         = 1'b0;
        instr_valid_i = 1'b0;
        instr_i       = '0;
        csr_wr_data_i = '0;
        pc_i          = '0;
        ex_pc_i       = '0;
        id_pc_i       = '0;
        if_pc_i       = '0;
        stall_n_i     = 1'b1;
        timer_int_i   = 1'b0;
        error_count   = 0;
        test_errors   = 0;
        tests_done    = 0;
        last_rd       = '0;
        last_redir    = '0;
        last_pending  = 1'b0;
        model_reset();
        repeat (8) @(posedge clk);
        #1;
        rst_n = 1'b1;

        test_reset_values();
        test_csr_ops();
        test_stall();
        test_ecall_mret();
        test_timer();

        $display("tests run %0d, errors %0d", tests_done, error_count);
        if (error_count == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule
